// File: bench/ltssm_patterns.txt
// columns: width mask, width cycle, complete mask, complete cycle, idle cycle,
// reconfig count, ready mode (1 random), outcome (1 success, 2 error), set count (00 any)
f_01_f_01_01_0_0_1_14
1_01_f_01_01_0_0_1_14
// width never satisfied, long timeout
0_00_f_01_01_0_0_2_00
// lane reconfig requests
f_01_f_01_01_2_0_1_16
f_01_f_01_01_1_0_1_15
// one lane never completes, then a clean rerun
f_01_7_01_01_0_0_2_00
f_01_f_01_01_0_0_1_14
// random back-pressure
f_01_f_01_01_0_1_1_14
f_01_f_01_01_3_1_1_17
0_00_f_01_01_0_1_2_00
e_01_b_01_01_0_1_2_00
// late status changes
f_28_f_50_60_0_0_1_00
f_28_f_50_60_1_1_1_00
2_10_f_30_90_0_0_1_00

// File: sources.f
+incdir+design
design/ltssm_cfg_pkg.sv
design/os_encoder.sv
design/os_serializer.sv
design/config_timer.sv
design/ltssm_config_fsm.sv
design/ltssm_config.sv
bench/tb_clock_gen.sv
bench/tb_ltssm_config.sv

// File: run_sim.sh
#!/bin/sh
# build and run the ltssm config testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module tb_ltssm_config -o sim_tb
./obj_dir/sim_tb > sim.log
cat sim.log

if grep -q "Test completed successfully" sim.log; then
  echo "simulation passed"
else
  echo "simulation FAILED"
  exit 1
fi

// File: bench/tb_ltssm_config.sv
// ========================================
// testbench for the ltssm config stage
// ========================================
`include "ltssm_macros.svh"

module tb_ltssm_config;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int PH_LINK = 0;
  localparam int PH_LANE = 1;
  localparam int PH_TS2 = 2;
  localparam int PH_IDLE = 3;
  localparam int PH_DONE = 4;
  localparam int TEST_CYCLES = int'(`LTSSM_TIMEOUT_LONG) + 40 * 4 * 4;

  logic clk;
  logic rst;
  logic en;
  logic ready;
  ltssm_cfg_pkg::link_status_t status;
  ltssm_cfg_pkg::tx_word_t tdata;
  logic tvalid;
  logic tlast;
  logic success;
  logic error;

  logic [51:0] pat_mem [0:31];
  int n_tests;
  int err_count;
  int fail_tests;
  bit active;
  int phase;
  int word_idx;
  int idle_seen;
  int set_cnt;
  int lane_sets_done;
  int reconfigs;

  tb_clock_gen u_clk (
    .clk_o (clk),
    .rst_o (rst)
  );

  ltssm_config u_dut (
    .clk_i      (clk),
    .rst_i      (rst),
    .en_i       (en),
    .status_i   (status),
    .m_tdata_o  (tdata),
    .m_tvalid_o (tvalid),
    .m_tlast_o  (tlast),
    .m_tready_i (ready),
    .success_o  (success),
    .error_o    (error)
  );

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0d ns: %s got %h expected %h", $time, name, got, exp);
      err_count++;
    end
  endtask

  // word of an ordered set, bytes low to high
  function automatic logic [31:0] expected_word(input int kind, input int idx);
    logic [7:0] b [4];
    logic [7:0] id;
    id = (kind == PH_TS2) ? `LTSSM_TS2_ID : `LTSSM_TS1_ID;
    if (kind == PH_IDLE) begin
      return 32'h0;
    end
    if (idx == 0) begin
      b[0] = `LTSSM_SYM_COM;
      b[1] = `LTSSM_LINK_NUM;
      b[2] = (kind == PH_LINK) ? `LTSSM_SYM_PAD : 8'h00;
      b[3] = `LTSSM_NFTS;
    end else if (idx == 1) begin
      b[0] = `LTSSM_RATE_BYTE;
      b[1] = 8'h00;
      b[2] = id;
      b[3] = id;
    end else begin
      b[0] = id;
      b[1] = id;
      b[2] = id;
      b[3] = id;
    end
    return {b[3], b[2], b[1], b[0]};
  endfunction

  // next set kind from the status seen at the end of a set
  task automatic finish_set();
    case (phase)
      PH_LINK: begin
        if (|status.width_satisfied) begin
          phase = PH_LANE;
        end
      end
      PH_LANE: begin
        lane_sets_done++;
        if (lane_sets_done == reconfigs + 1) begin
          phase = PH_TS2;
        end
      end
      PH_TS2: begin
        if (&status.complete_ts2) begin
          phase = PH_IDLE;
          idle_seen = 0;
        end
      end
      default: begin
        if (status.link_idle_satisfied && idle_seen >= 32'(`LTSSM_IDLE_MIN)) begin
          phase = PH_DONE;
        end
        if (status.single_idle_received) begin
          idle_seen++;
        end
      end
    endcase
  endtask

  // stream monitor
  always @(posedge clk) begin
    if (!rst && tvalid && ready) begin
      if (!active) begin
        $display("word accepted at %0d ns while the port is disabled", $time);
        err_count++;
      end else if (phase == PH_DONE) begin
        $display("word accepted at %0d ns after the training outcome", $time);
        err_count++;
      end else begin
        check_value("m_tdata_o", tdata, expected_word(phase, word_idx));
        check_value("m_tlast_o", 32'(tlast), 32'(word_idx == 3));
        if (word_idx == 3) begin
          word_idx = 0;
          set_cnt++;
          finish_set();
        end else begin
          word_idx++;
        end
      end
    end
  end

  task automatic run_test(input int t);
    logic [51:0] p;
    int w_cyc;
    int c_cyc;
    int i_cyc;
    int rnd_mode;
    int outcome;
    int exp_sets;
    int cyc;
    int lane_handled;
    int start_err;
    bit done;
    p = pat_mem[t];
    w_cyc = 32'(p[47:40]);
    c_cyc = 32'(p[35:28]);
    i_cyc = 32'(p[27:20]);
    reconfigs = 32'(p[19:16]);
    rnd_mode = 32'(p[15:12]);
    outcome = 32'(p[11:8]);
    exp_sets = 32'(p[7:0]);
    start_err = err_count;
    phase = PH_LINK;
    word_idx = 0;
    set_cnt = 0;
    lane_sets_done = 0;
    lane_handled = 0;
    @(negedge clk);
    check_value("m_tvalid_o", 32'(tvalid), 32'h0);
    check_value("success_o", 32'(success), 32'h0);
    check_value("error_o", 32'(error), 32'h0);
    active = 1'b1;
    en = 1'b1;
    cyc = 0;
    done = 1'b0;
    while (!done && cyc < TEST_CYCLES) begin
      if (cyc >= w_cyc && p[51:48] != 4'h0) begin
        status.width_satisfied = p[51:48];
        status.lanes_formed = 1'b1;
      end
      if (cyc >= c_cyc) begin
        status.complete_ts2 = p[39:36];
      end
      if (cyc >= i_cyc) begin
        status.single_idle_received = 1'b1;
        status.link_idle_satisfied = 1'b1;
      end
      // one reconfig pulse per lane set until the count is used up
      status.lane_reconfig = 1'b0;
      if (lane_handled < lane_sets_done) begin
        lane_handled++;
        if (lane_handled <= reconfigs) begin
          status.lane_reconfig = 1'b1;
        end else begin
          status.lane_nums_match = 1'b1;
        end
      end
      ready = (rnd_mode != 0) ? (($urandom % 4) != 0) : 1'b1;
      @(negedge clk);
      cyc++;
      done = success || error;
    end
    if (!done) begin
      $display("test %0d gave no outcome within %0d cycles", t, TEST_CYCLES);
      err_count++;
    end
    check_value("success_o", 32'(success), 32'(outcome == 1));
    check_value("error_o", 32'(error), 32'(outcome == 2));
    if (outcome == 1) begin
      check_value("final phase", 32'(phase), 32'(PH_DONE));
    end
    if (exp_sets != 0) begin
      check_value("set count", 32'(set_cnt), 32'(exp_sets));
    end
    // no further set may follow the outcome
    phase = PH_DONE;
    repeat (2) @(negedge clk);
    // outcome holds while en_i stays high
    check_value("success_o", 32'(success), 32'(outcome == 1));
    check_value("error_o", 32'(error), 32'(outcome == 2));
    en = 1'b0;
    status = '0;
    ready = 1'b1;
    @(negedge clk);
    check_value("success_o", 32'(success), 32'h0);
    check_value("error_o", 32'(error), 32'h0);
    active = 1'b0;
    if (err_count == start_err) begin
      $display("test %0d: pass, %0d sets", t, set_cnt);
    end else begin
      $display("test %0d: fail, %0d errors", t, err_count - start_err);
      fail_tests++;
    end
  endtask

  // watchdog sized from the test count
  initial begin
    longint limit;
    wait (n_tests > 0);
    limit = longint'(n_tests + 1) * longint'(TEST_CYCLES + 50) * 40;
    #(limit);
    $display("watchdog expired after %0d ns, run did not finish", limit);
    $display("Test failed");
    $finish;
  end

  initial begin
    en = 1'b0;
    ready = 1'b1;
    status = '0;
    err_count = 0;
    fail_tests = 0;
    active = 1'b0;
    n_tests = 0;
    void'($urandom(53101));
    for (int i = 0; i < 32; i++) begin
      pat_mem[i] = '0;
    end
    $readmemh("bench/ltssm_patterns.txt", pat_mem);
    while (n_tests < 32 && pat_mem[n_tests] != '0) begin
      n_tests++;
    end
    if (n_tests == 0) begin
      $display("no test patterns found in the pattern file");
      err_count++;
    end
    @(negedge rst);
    // nothing may leave the port while en_i is low
    repeat (5) begin
      @(negedge clk);
      check_value("m_tvalid_o", 32'(tvalid), 32'h0);
      check_value("success_o", 32'(success), 32'h0);
      check_value("error_o", 32'(error), 32'h0);
    end
    $display("test idle after reset: %s", (err_count == 0) ? "pass" : "fail");
    for (int t = 0; t < n_tests; t++) begin
      run_test(t);
    end
    $display("tests run %0d, tests failed %0d, checks failed %0d",
             n_tests, fail_tests, err_count);
    if (err_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: bench/tb_clock_gen.sv
// ========================================
// testbench clock, 40 ns period, and reset
// ========================================
module tb_clock_gen (
  output logic clk_o,
  output logic rst_o
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  // reset held for three rising edges
  initial begin
    rst_o = 1'b1;
    repeat (3) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

// File: design/ltssm_config.sv
// ========================================
// ltssm configuration stage, downstream
// port, ordered sets out on a stream
// ========================================
module ltssm_config (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        en_i,
  input  ltssm_cfg_pkg::link_status_t status_i,
  output ltssm_cfg_pkg::tx_word_t     m_tdata_o,
  output logic                        m_tvalid_o,
  output logic                        m_tlast_o,
  input  logic                        m_tready_i,
  output logic                        success_o,
  output logic                        error_o
);

  ltssm_cfg_pkg::os_kind_e   os_kind;
  ltssm_cfg_pkg::word_idx_t  os_index;
  ltssm_cfg_pkg::tx_word_t   os_word;
  logic                      os_start;
  logic                      os_done;
  logic                      timer_clear;
  logic                      long_expired;
  logic                      short_expired;

  os_encoder u_encoder (
    .kind_i  (os_kind),
    .index_i (os_index),
    .word_o  (os_word)
  );

  os_serializer u_serializer (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .start_i    (os_start),
    .word_i     (os_word),
    .index_o    (os_index),
    .done_o     (os_done),
    .m_tdata_o  (m_tdata_o),
    .m_tvalid_o (m_tvalid_o),
    .m_tlast_o  (m_tlast_o),
    .m_tready_i (m_tready_i)
  );

  config_timer u_timer (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .clear_i         (timer_clear),
    .long_expired_o  (long_expired),
    .short_expired_o (short_expired)
  );

  ltssm_config_fsm u_fsm (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .en_i            (en_i),
    .status_i        (status_i),
    .os_done_i       (os_done),
    .long_expired_i  (long_expired),
    .short_expired_i (short_expired),
    .os_start_o      (os_start),
    .os_kind_o       (os_kind),
    .timer_clear_o   (timer_clear),
    .success_o       (success_o),
    .error_o         (error_o)
  );

endmodule

// File: design/ltssm_config_fsm.sv
// ========================================
// configuration substate FSM: picks the
// ordered sets and raises success or error
// ========================================
`include "ltssm_macros.svh"

module ltssm_config_fsm (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        en_i,
  input  ltssm_cfg_pkg::link_status_t status_i,
  input  logic                        os_done_i,
  input  logic                        long_expired_i,
  input  logic                        short_expired_i,
  output logic                        os_start_o,
  output ltssm_cfg_pkg::os_kind_e     os_kind_o,
  output logic                        timer_clear_o,
  output logic                        success_o,
  output logic                        error_o
);

  ltssm_cfg_pkg::cfg_state_e state_r;
  ltssm_cfg_pkg::cfg_state_e state_c;
  ltssm_cfg_pkg::os_kind_e   os_kind_r;
  ltssm_cfg_pkg::os_kind_e   os_kind_c;
  ltssm_cfg_pkg::idle_cnt_t  idle_cnt_r;
  ltssm_cfg_pkg::idle_cnt_t  idle_cnt_c;
  logic                      os_start_r;
  logic                      os_start_c;
  logic                      success_r;
  logic                      success_c;
  logic                      error_r;
  logic                      error_c;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_r    <= ltssm_cfg_pkg::ST_IDLE;
      os_kind_r  <= ltssm_cfg_pkg::OS_TS1_LINK;
      idle_cnt_r <= '0;
      os_start_r <= 1'b0;
      success_r  <= 1'b0;
      error_r    <= 1'b0;
    end else begin
      state_r    <= state_c;
      os_kind_r  <= os_kind_c;
      idle_cnt_r <= idle_cnt_c;
      os_start_r <= os_start_c;
      success_r  <= success_c;
      error_r    <= error_c;
    end
  end

  always_comb begin
    state_c       = state_r;
    os_kind_c     = os_kind_r;
    idle_cnt_c    = idle_cnt_r;
    os_start_c    = 1'b0;
    success_c     = success_r;
    error_c       = error_r;
    timer_clear_o = 1'b0;
    case (state_r)
      ltssm_cfg_pkg::ST_IDLE: begin
        if (en_i) begin
          timer_clear_o = 1'b1;
          idle_cnt_c    = '0;
          os_kind_c     = ltssm_cfg_pkg::OS_TS1_LINK;
          os_start_c    = 1'b1;
          state_c       = ltssm_cfg_pkg::ST_LW_SEND;
        end
      end
      ltssm_cfg_pkg::ST_LW_SEND: begin
        // decisions only at the end of a set
        if (os_done_i) begin
          if (|status_i.width_satisfied) begin
            timer_clear_o = 1'b1;
            state_c       = ltssm_cfg_pkg::ST_LW_ACCEPT;
          end else if (long_expired_i) begin
            error_c = 1'b1;
            state_c = ltssm_cfg_pkg::ST_WAIT_EN_LOW;
          end else begin
            os_start_c = 1'b1;
          end
        end
      end
      ltssm_cfg_pkg::ST_LW_ACCEPT: begin
        if (status_i.lanes_formed) begin
          os_kind_c  = ltssm_cfg_pkg::OS_TS1_LANE;
          os_start_c = 1'b1;
          state_c    = ltssm_cfg_pkg::ST_LN_SEND;
        end else if (short_expired_i) begin
          error_c = 1'b1;
          state_c = ltssm_cfg_pkg::ST_WAIT_EN_LOW;
        end
      end
      ltssm_cfg_pkg::ST_LN_SEND: begin
        if (os_done_i) begin
          state_c = ltssm_cfg_pkg::ST_LN_ACCEPT;
        end
      end
      ltssm_cfg_pkg::ST_LN_ACCEPT: begin
        if (status_i.lane_nums_match) begin
          timer_clear_o = 1'b1;
          os_kind_c     = ltssm_cfg_pkg::OS_TS2;
          os_start_c    = 1'b1;
          state_c       = ltssm_cfg_pkg::ST_COMPLETE_SEND;
        end else if (status_i.lane_reconfig) begin
          // repeat the lane numbers
          os_start_c = 1'b1;
          state_c    = ltssm_cfg_pkg::ST_LN_SEND;
        end
      end
      ltssm_cfg_pkg::ST_COMPLETE_SEND: begin
        if (os_done_i) begin
          if (&status_i.complete_ts2) begin
            idle_cnt_c = '0;
            os_kind_c  = ltssm_cfg_pkg::OS_IDLE;
            os_start_c = 1'b1;
            state_c    = ltssm_cfg_pkg::ST_IDLE_SEND;
          end else if (short_expired_i) begin
            error_c = 1'b1;
            state_c = ltssm_cfg_pkg::ST_WAIT_EN_LOW;
          end else begin
            os_start_c = 1'b1;
          end
        end
      end
      ltssm_cfg_pkg::ST_IDLE_SEND: begin
        if (os_done_i) begin
          if (status_i.single_idle_received && (idle_cnt_r != '1)) begin
            idle_cnt_c = idle_cnt_r + 1'b1;
          end
          // compare uses the count before this set
          if (status_i.link_idle_satisfied && (idle_cnt_r >= `LTSSM_IDLE_MIN)) begin
            success_c = 1'b1;
            state_c   = ltssm_cfg_pkg::ST_WAIT_EN_LOW;
          end else begin
            os_start_c = 1'b1;
          end
        end
      end
      ltssm_cfg_pkg::ST_WAIT_EN_LOW: begin
        if (!en_i) begin
          success_c = 1'b0;
          error_c   = 1'b0;
          state_c   = ltssm_cfg_pkg::ST_IDLE;
        end
      end
      default: begin
        state_c = ltssm_cfg_pkg::ST_IDLE;
      end
    endcase
  end

  assign os_start_o = os_start_r;
  assign os_kind_o  = os_kind_r;
  assign success_o  = success_r;
  assign error_o    = error_r;

endmodule

// File: design/config_timer.sv
// ========================================
// config state timer: saturating counter
// with long and short expiry flags
// ========================================
`include "ltssm_macros.svh"

module config_timer (
  input  logic clk_i,
  input  logic rst_i,
  input  logic clear_i,
  output logic long_expired_o,
  output logic short_expired_o
);

  ltssm_cfg_pkg::timer_cnt_t cnt_r;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      cnt_r <= '0;
    end else if (clear_i) begin
      cnt_r <= '0;
    end else if (cnt_r < `LTSSM_TIMEOUT_LONG) begin
      cnt_r <= cnt_r + 1'b1;
    end
  end

  // stops at the long limit
  assign long_expired_o  = (cnt_r >= `LTSSM_TIMEOUT_LONG);
  assign short_expired_o = (cnt_r >= `LTSSM_TIMEOUT_SHORT);

endmodule

// File: design/os_serializer.sv
// ========================================
// ordered set serializer: one set, word by
// word, on the valid/ready stream
// ========================================
`include "ltssm_macros.svh"

module os_serializer (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     start_i,
  input  ltssm_cfg_pkg::tx_word_t  word_i,
  output ltssm_cfg_pkg::word_idx_t index_o,
  output logic                     done_o,
  output ltssm_cfg_pkg::tx_word_t  m_tdata_o,
  output logic                     m_tvalid_o,
  output logic                     m_tlast_o,
  input  logic                     m_tready_i
);

  localparam ltssm_cfg_pkg::word_idx_t last_idx = ltssm_cfg_pkg::word_idx_t'(`LTSSM_OS_WORDS - 1);

  logic                     busy_r;
  ltssm_cfg_pkg::word_idx_t idx_r;
  logic                     accept;
  logic                     at_last;

  assign accept  = busy_r && m_tready_i;
  assign at_last = (idx_r == last_idx);

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      busy_r <= 1'b0;
      idx_r  <= '0;
    end else begin
      if (!busy_r) begin
        if (start_i) begin
          busy_r <= 1'b1;
          idx_r  <= '0;
        end
      end else if (accept) begin
        if (at_last) begin
          // set finished, valid drops for at least one cycle
          busy_r <= 1'b0;
          idx_r  <= '0;
        end else begin
          idx_r <= idx_r + 1'b1;
        end
      end
    end
  end

  // word follows the index, so it holds under back-pressure
  assign index_o    = idx_r;
  assign m_tdata_o  = word_i;
  assign m_tvalid_o = busy_r;
  assign m_tlast_o  = busy_r && at_last;
  assign done_o     = accept && at_last;

endmodule

// File: design/os_encoder.sv
// ========================================
// ordered set encoder: TS1, TS2 and idle
// words by set kind and word index
// ========================================
`include "ltssm_macros.svh"

module os_encoder (
  input  ltssm_cfg_pkg::os_kind_e  kind_i,
  input  ltssm_cfg_pkg::word_idx_t index_i,
  output ltssm_cfg_pkg::tx_word_t  word_o
);

  logic [7:0] ts_id;
  logic [7:0] lane_byte;

  // identifier and lane symbol for the TS sets
  always_comb begin
    ts_id = `LTSSM_TS1_ID;
    if (kind_i == ltssm_cfg_pkg::OS_TS2) begin
      ts_id = `LTSSM_TS2_ID;
    end
    lane_byte = 8'h00;
    if (kind_i == ltssm_cfg_pkg::OS_TS1_LINK) begin
      lane_byte = `LTSSM_SYM_PAD;
    end
  end

  // byte 0 sits in the low bits of each word
  always_comb begin
    word_o = '0;
    if (kind_i != ltssm_cfg_pkg::OS_IDLE) begin
      case (index_i)
        2'd0: begin
          word_o = {`LTSSM_NFTS, lane_byte, `LTSSM_LINK_NUM, `LTSSM_SYM_COM};
        end
        2'd1: begin
          word_o = {ts_id, ts_id, 8'h00, `LTSSM_RATE_BYTE};
        end
        default: begin
          word_o = {4{ts_id}};
        end
      endcase
    end
  end

endmodule

// File: design/ltssm_cfg_pkg.sv
// ========================================
// ltssm config types: stream words, lane
// status and the state enums
// ========================================
`include "ltssm_macros.svh"

package ltssm_cfg_pkg;

  typedef logic [31:0] tx_word_t;
  typedef logic [`LTSSM_LANES-1:0] lane_mask_t;
  typedef logic [15:0] timer_cnt_t;
  typedef logic [7:0] idle_cnt_t;
  typedef logic [$clog2(`LTSSM_OS_WORDS)-1:0] word_idx_t;

  // ordered set requested from the encoder
  typedef enum logic [1:0] {
    OS_TS1_LINK,
    OS_TS1_LANE,
    OS_TS2,
    OS_IDLE
  } os_kind_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LW_SEND,
    ST_LW_ACCEPT,
    ST_LN_SEND,
    ST_LN_ACCEPT,
    ST_COMPLETE_SEND,
    ST_IDLE_SEND,
    ST_WAIT_EN_LOW
  } cfg_state_e;

  // status reported by the receive lanes
  typedef struct packed {
    lane_mask_t width_satisfied;
    lane_mask_t complete_ts2;
    logic       lanes_formed;
    logic       lane_nums_match;
    logic       lane_reconfig;
    logic       single_idle_received;
    logic       link_idle_satisfied;
  } link_status_t;

endpackage

// File: design/ltssm_macros.svh
// ========================================
// ltssm config constants: lane count, symbol
// codes and scaled timeout limits
// ========================================
`ifndef LTSSM_MACROS_SVH
`define LTSSM_MACROS_SVH

// link geometry
`define LTSSM_LANES 4
`define LTSSM_OS_WORDS 4
`define LTSSM_LINK_NUM 8'd0
`define LTSSM_NFTS 8'h20

// symbol codes
`define LTSSM_SYM_COM 8'hBC
`define LTSSM_SYM_PAD 8'hF7
`define LTSSM_TS1_ID 8'h4A
`define LTSSM_TS2_ID 8'h45
`define LTSSM_RATE_BYTE 8'h06

// timeouts in clock cycles, scaled down from 24 ms and 2 ms
`define LTSSM_TIMEOUT_LONG 16'd300
`define LTSSM_TIMEOUT_SHORT 16'd60

// received idle sets needed before success
`define LTSSM_IDLE_MIN 8'd16

`endif
